// ==== verilog/cpuCfg.svh ====
// Architectural sizes of the pipelined MIPS subset core, included by the RTL and the testbench
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and instruction word width
`define CPU_XLEN 32

// Architectural register count
`define CPU_NREGS 32

// Instruction memory size in words
`define CPU_IMEM_DEPTH 64

// Must cover CPU_IMEM_DEPTH
`define CPU_IMEM_AW 6

`endif

// ==== verilog/cpuPkg.sv ====
// Shared types of the pipelined core, used by every stage through cpuPkg:: scoped names
`default_nettype none

`include "cpuCfg.svh"

package cpuPkg;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,                               // Signed compare
        aluLui = 3'd5                                // Pass operand B
    } aluOp_e;

    // Fetch register output
    typedef struct packed {
        logic [`CPU_XLEN-1:0] instr;
        logic                 valid;
    } fetchOut_t;

    // Decoded control for one instruction
    typedef struct packed {
        aluOp_e                         aluOp;
        logic [$clog2(`CPU_NREGS)-1:0]  srcA;
        logic [$clog2(`CPU_NREGS)-1:0]  srcB;
        logic [$clog2(`CPU_NREGS)-1:0]  dest;
        logic                           useImm;
        logic [`CPU_XLEN-1:0]           imm;     // Already extended or shifted
        logic                           regWrite;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] dataA;
        logic [`CPU_XLEN-1:0] dataB;
    } regRead_t;

    // Writeback bus, also the core output
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`CPU_NREGS)-1:0]  dest;
        logic [`CPU_XLEN-1:0]           value;
    } wbResult_t;

endpackage

`default_nettype wire

// ==== verilog/fetchUnit.sv ====
// Fetch stage with PC, testbench-loadable instruction memory and the fetch register
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    loadEn,
    input  logic [`CPU_IMEM_AW-1:0] loadAddr,
    input  logic [`CPU_XLEN-1:0]    loadData,
    output cpuPkg::fetchOut_t       fetchOut
);

    logic [`CPU_XLEN-1:0]    imem [`CPU_IMEM_DEPTH];
    logic [`CPU_IMEM_AW-1:0] pc;
    logic                    done;               // Last word already issued
    logic                    issue;
    logic                    lastWord;

    assign issue    = run && !done;
    assign lastWord = (pc == (`CPU_IMEM_AW)'(`CPU_IMEM_DEPTH - 1));

    // Loading only happens while the core is halted
    always_ff @(posedge clk) begin
        if (loadEn && !run) begin
            imem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= '0;
            done <= 1'b0;
        end else if (issue) begin
            if (lastWord) begin
                done <= 1'b1;                    // Stop until the next reset
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Synchronous read into the fetch register
    always_ff @(posedge clk) begin
        fetchOut.instr <= imem[pc];
        if (rst) begin
            fetchOut.valid <= 1'b0;
        end else begin
            fetchOut.valid <= issue;             // Drops as soon as run falls
        end
    end

    // The testbench must halt the core before touching program memory
    noLoadWhileRun: assert property (
        @(posedge clk) disable iff (rst) !(loadEn && run)
    ) else $error("instruction memory written while run is high");

endmodule

`default_nettype wire

// ==== verilog/controlDecoder.sv ====
// Combinational decoder from the fetched word to the control struct and extended immediate
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module controlDecoder (
    input  cpuPkg::fetchOut_t fetchOut,
    output cpuPkg::ctrl_t     ctrl
);

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLui   = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_e;

    opcode_e          opcode;
    funct_e           funct;
    logic [15:0]      imm16;
    logic [4:0]       rt;
    logic [4:0]       rd;
    logic             supported;

    assign opcode = opcode_e'(fetchOut.instr[31:26]);
    assign funct  = funct_e'(fetchOut.instr[5:0]);
    assign imm16  = fetchOut.instr[15:0];
    assign rt     = fetchOut.instr[20:16];
    assign rd     = fetchOut.instr[15:11];

    always_comb begin
        ctrl.aluOp  = cpuPkg::aluAdd;
        ctrl.srcA   = fetchOut.instr[25:21];
        ctrl.srcB   = rt;
        ctrl.dest   = rt;                        // Immediate forms write rt
        ctrl.useImm = 1'b1;
        ctrl.imm    = {{(`CPU_XLEN-16){imm16[15]}}, imm16};
        supported   = 1'b1;

        case (opcode)
            opRType: begin
                ctrl.dest   = rd;
                ctrl.useImm = 1'b0;
                case (funct)
                    fnAdd:   ctrl.aluOp = cpuPkg::aluAdd;
                    fnSub:   ctrl.aluOp = cpuPkg::aluSub;
                    fnAnd:   ctrl.aluOp = cpuPkg::aluAnd;
                    fnOr:    ctrl.aluOp = cpuPkg::aluOr;
                    fnSlt:   ctrl.aluOp = cpuPkg::aluSlt;
                    default: supported  = 1'b0;  // Includes the all-zero word
                endcase
            end
            opAddi:  ctrl.aluOp = cpuPkg::aluAdd;
            opSlti:  ctrl.aluOp = cpuPkg::aluSlt;
            opAndi: begin
                ctrl.aluOp = cpuPkg::aluAnd;
                ctrl.imm   = {{(`CPU_XLEN-16){1'b0}}, imm16};
            end
            opOri: begin
                ctrl.aluOp = cpuPkg::aluOr;
                ctrl.imm   = {{(`CPU_XLEN-16){1'b0}}, imm16};
            end
            opLui: begin
                ctrl.aluOp = cpuPkg::aluLui;
                ctrl.imm   = {imm16, {(`CPU_XLEN-16){1'b0}}};
            end
            default: supported = 1'b0;
        endcase

        // Writes to r0 are dropped here so later stages never see them
        ctrl.regWrite = fetchOut.valid && supported && (ctrl.dest != '0);
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// Register file with two combinational read ports, one write port and write-to-read bypass
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module regFile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(`CPU_NREGS)-1:0] rdAddrA,
    input  logic [$clog2(`CPU_NREGS)-1:0] rdAddrB,
    output cpuPkg::regRead_t              rdData,
    input  cpuPkg::wbResult_t             wb
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    function automatic logic [`CPU_XLEN-1:0] readPort(
        input logic [$clog2(`CPU_NREGS)-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wb.valid && wb.dest == addr) begin
            return wb.value;                     // Same-cycle write is visible
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.value;
        end
    end

    always_comb begin
        rdData.dataA = readPort(rdAddrA);
        rdData.dataB = readPort(rdAddrB);
    end

    // Decode drops r0 destinations, so none may reach the write port
    noWriteToZero: assert property (
        @(posedge clk) disable iff (rst) wb.valid |-> (wb.dest != '0)
    ) else $error("writeback targets register zero");

endmodule

`default_nettype wire

// ==== verilog/executeUnit.sv ====
// Execute stage with decode-to-execute register, forwarding, ALU and writeback register
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module executeUnit (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::ctrl_t     ctrl,
    input  cpuPkg::regRead_t  regRead,
    output cpuPkg::wbResult_t wb
);

    cpuPkg::ctrl_t        exCtrl;
    cpuPkg::regRead_t     exRead;
    logic [`CPU_XLEN-1:0] opA;
    logic [`CPU_XLEN-1:0] fwdB;
    logic [`CPU_XLEN-1:0] opB;
    logic [`CPU_XLEN-1:0] result;
    logic                 hitA;
    logic                 hitB;

    // Decode-to-execute register
    always_ff @(posedge clk) begin
        exCtrl <= ctrl;
        exRead <= regRead;
        if (rst) begin
            exCtrl.regWrite <= 1'b0;
        end
    end

    // Previous instruction's result is still in the writeback register
    assign hitA = wb.valid && (wb.dest == exCtrl.srcA);
    assign hitB = wb.valid && (wb.dest == exCtrl.srcB);

    assign opA  = hitA ? wb.value : exRead.dataA;
    assign fwdB = hitB ? wb.value : exRead.dataB;
    assign opB  = exCtrl.useImm ? exCtrl.imm : fwdB;

    always_comb begin
        case (exCtrl.aluOp)
            cpuPkg::aluAdd: result = opA + opB;
            cpuPkg::aluSub: result = opA - opB;
            cpuPkg::aluAnd: result = opA & opB;
            cpuPkg::aluOr:  result = opA | opB;
            cpuPkg::aluSlt: begin
                result = {{(`CPU_XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
            end
            cpuPkg::aluLui: result = opB;        // Immediate already in upper half
            default:        result = '0;
        endcase
    end

    // Writeback register
    always_ff @(posedge clk) begin
        wb.dest  <= exCtrl.dest;
        wb.value <= result;
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exCtrl.regWrite;
        end
    end

    // Second cycle depends on the cleared decode-to-execute register
    wbQuietAfterReset: assert property (
        @(posedge clk) rst |=> !wb.valid ##1 !wb.valid
    ) else $error("writeback valid right after reset");

endmodule

`default_nettype wire

// ==== verilog/pipelineCpu.sv ====
// Top of the three-stage MIPS subset core, connecting fetch, decode, register file and execute
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module pipelineCpu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    loadEn,
    input  logic [`CPU_IMEM_AW-1:0] loadAddr,
    input  logic [`CPU_XLEN-1:0]    loadData,
    output cpuPkg::wbResult_t       wb
);

    cpuPkg::fetchOut_t fetchOut;
    cpuPkg::ctrl_t     ctrl;
    cpuPkg::regRead_t  regRead;

    fetchUnit i_fetch (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .fetchOut (fetchOut)
    );

    // Decoder and register file work on the same fetched word
    controlDecoder i_decode (
        .fetchOut (fetchOut),
        .ctrl     (ctrl)
    );

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (fetchOut.instr[25:21]),     // rs
        .rdAddrB (fetchOut.instr[20:16]),     // rt
        .rdData  (regRead),
        .wb      (wb)
    );

    executeUnit i_execute (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .regRead (regRead),
        .wb      (wb)
    );

endmodule

`default_nettype wire

// ==== tests/tbPipelineCpu.sv ====
// Self-checking testbench that runs a random program through the core against an in-order model
`timescale 1ns/1ns
`default_nettype none

`include "cpuCfg.svh"

module tbPipelineCpu;

    localparam int progLen     = 48;
    localparam int resetCycles = 8;
    localparam int latency     = 3;                  // Fetch to writeback pulse
    localparam int runCycles   = progLen + 20;       // Covers every slot of the memory
    localparam int maxCycles   = 2 * (resetCycles + `CPU_IMEM_DEPTH + runCycles) + 8;

    logic                    clk;
    logic                    rst;
    logic                    run;
    logic                    loadEn;
    logic [`CPU_IMEM_AW-1:0] loadAddr;
    logic [`CPU_XLEN-1:0]    loadData;
    cpuPkg::wbResult_t       wb;

    logic [15:0]             lfsr;
    logic [`CPU_XLEN-1:0]    prog [`CPU_IMEM_DEPTH];
    logic [`CPU_XLEN-1:0]    model [`CPU_NREGS];
    cpuPkg::wbResult_t       expWb [$];
    int                      expSlot [$];
    int                      errors = 0;
    int                      totalCycles = 0;

    pipelineCpu i_dut (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .wb       (wb)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Small pool r0..r7 so that dependencies are frequent
    function automatic logic [4:0] pickReg();
        return 5'(takeBits(3));
    endfunction

    function automatic logic [5:0] pickFunct();
        logic [2:0] sel;
        sel = 3'(takeBits(3));
        case (sel)
            3'd0, 3'd5: return 6'h20;
            3'd1, 3'd6: return 6'h22;
            3'd2:       return 6'h24;
            3'd3:       return 6'h25;
            default:    return 6'h2a;
        endcase
    endfunction

    task automatic buildProgram();
        logic [3:0]  cls;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  funct;
        for (int k = 0; k < `CPU_IMEM_DEPTH; k++) begin
            prog[k] = '0;                            // Tail words are no-ops
        end
        for (int k = 0; k < progLen; k++) begin
            cls   = 4'(takeBits(4));
            rs    = pickReg();
            rt    = pickReg();
            rd    = pickReg();
            imm   = 16'(takeBits(16));
            funct = pickFunct();
            case (cls)
                4'd6, 4'd11: prog[k] = {6'h08, rs, rt, imm};
                4'd7:        prog[k] = {6'h0a, rs, rt, imm};
                4'd8:        prog[k] = {6'h0c, rs, rt, imm};
                4'd9:        prog[k] = {6'h0d, rs, rt, imm};
                4'd10:       prog[k] = {6'h0f, rs, rt, imm};
                4'd12:       prog[k] = '0;
                4'd13:       prog[k] = {6'h23, rs, rt, imm};                 // lw
                4'd14:       prog[k] = {6'h00, rs, rt, rd, 5'd0, 6'h21};     // addu
                default:     prog[k] = {6'h00, rs, rt, rd, 5'd0, funct};
            endcase
        end
    endtask

    function automatic logic [`CPU_XLEN-1:0] aluModel(
        input cpuPkg::aluOp_e       op,
        input logic [`CPU_XLEN-1:0] a,
        input logic [`CPU_XLEN-1:0] b
    );
        case (op)
            cpuPkg::aluAdd: return a + b;
            cpuPkg::aluSub: return a - b;
            cpuPkg::aluAnd: return a & b;
            cpuPkg::aluOr:  return a | b;
            cpuPkg::aluSlt: return {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:        return b;
        endcase
    endfunction

    // Executes the whole memory in order and queues one expected pulse per register write
    task automatic runModel();
        logic [5:0]           opcode;
        logic [4:0]           dest;
        logic [15:0]          imm;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        logic                 writes;
        cpuPkg::aluOp_e       op;
        cpuPkg::wbResult_t    exp;
        expWb.delete();
        expSlot.delete();
        for (int r = 0; r < `CPU_NREGS; r++) begin
            model[r] = '0;
        end
        for (int k = 0; k < `CPU_IMEM_DEPTH; k++) begin
            opcode = prog[k][31:26];
            imm    = prog[k][15:0];
            a      = model[prog[k][25:21]];
            b      = {{(`CPU_XLEN-16){imm[15]}}, imm};
            dest   = prog[k][20:16];
            writes = 1'b1;
            op     = cpuPkg::aluAdd;
            case (opcode)
                6'h00: begin
                    dest = prog[k][15:11];
                    b    = model[prog[k][20:16]];
                    case (prog[k][5:0])
                        6'h20:   op = cpuPkg::aluAdd;
                        6'h22:   op = cpuPkg::aluSub;
                        6'h24:   op = cpuPkg::aluAnd;
                        6'h25:   op = cpuPkg::aluOr;
                        6'h2a:   op = cpuPkg::aluSlt;
                        default: writes = 1'b0;
                    endcase
                end
                6'h08: op = cpuPkg::aluAdd;
                6'h0a: op = cpuPkg::aluSlt;
                6'h0c: begin
                    op = cpuPkg::aluAnd;
                    b  = {{(`CPU_XLEN-16){1'b0}}, imm};
                end
                6'h0d: begin
                    op = cpuPkg::aluOr;
                    b  = {{(`CPU_XLEN-16){1'b0}}, imm};
                end
                6'h0f: begin
                    op = cpuPkg::aluLui;
                    b  = {imm, {(`CPU_XLEN-16){1'b0}}};
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                exp.valid   = 1'b1;
                exp.dest    = dest;
                exp.value   = aluModel(op, a, b);
                model[dest] = exp.value;
                expWb.push_back(exp);
                expSlot.push_back(k + latency);
            end
        end
    endtask

    task automatic checkWb(input cpuPkg::wbResult_t got, input cpuPkg::wbResult_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] wb: got valid=%h dest=%h value=%h, expected valid=%h dest=%h value=%h",
                     got.valid, got.dest, got.value, exp.valid, exp.dest, exp.value);
        end
    endtask

    task automatic checkTiming(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst    = 1'b1;
        run    = 1'b0;
        loadEn = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            @(negedge clk);
            if (wb.valid !== 1'b0) begin
                errors++;
                $display("Writeback pulse seen while reset is high");
            end
        end
        rst = 1'b0;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            loadEn   = 1'b1;
            loadAddr = (`CPU_IMEM_AW)'(i);
            loadData = prog[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
    endtask

    // Cycle n is the negedge after the n-th rising edge with run high
    task automatic runAndCheck();
        int                cycle;
        int                seen;
        int                total;
        cpuPkg::wbResult_t exp;
        cycle = 0;
        seen  = 0;
        total = expWb.size();
        run   = 1'b1;
        while (cycle < runCycles) begin
            @(negedge clk);
            cycle++;
            if (wb.valid !== 1'b0) begin
                seen++;
                if (expWb.size() == 0) begin
                    errors++;
                    $display("Unexpected writeback pulse in cycle %0d after run rose", cycle);
                end else begin
                    exp = expWb.pop_front();
                    checkWb(wb, exp);
                    checkTiming("wb cycle", cycle, expSlot.pop_front());
                end
            end
        end
        checkTiming("wb pulse count", seen, total);
        run = 1'b0;
    endtask

    always @(posedge clk) begin
        totalCycles <= totalCycles + 1;
        if (totalCycles >= maxCycles) begin
            $display("Timeout after %0d cycles without the run finishing", maxCycles);
            $display("Errors: %0d", errors + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lfsr     = 16'd54936;
        buildProgram();

        runModel();
        applyReset();
        loadProgram();
        runAndCheck();

        // Same program again after a fresh reset
        runModel();
        applyReset();
        loadProgram();
        runAndCheck();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/pipelineCpu.sv
tests/tbPipelineCpu.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbPipelineCpu \
    -f all.f -o simv || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Errors: 0" sim.log || { echo "No closing error count in the log"; exit 1; }
exit 0
